/* src.f */
common/nd_types_pkg.sv
common/nd_stream_pkg.sv
src/cmd_slice.sv
addr_gen/nd_addr_gen.sv
src/frame_ram.sv
src/read_pipe.sv
src/nd_frame_reader.sv
sim/tb_clock.sv
sim/nd_frame_reader_props.sv
sim/nd_frame_reader_tb.sv

/* sim/nd_frame_reader_tb.sv */
/*
 * directed tests for the strided frame reader
 * reference model, output and generator monitors, compare tasks
 */

module nd_frame_reader_tb import nd_types_pkg::*; import nd_stream_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam bit cmd_regs     = 1'b1;
    localparam int len_offset   = 1;
    localparam int accept_limit = 50;
    localparam int drain_limit  = 500;

    logic       clk;
    logic       reset;
    nd_cmd_t    cmd;
    logic       cmd_valid;
    logic       cmd_ready;
    logic       wr_en;
    addr_t      wr_addr;
    data_t      wr_data;
    data_beat_t out;
    logic       out_valid;
    logic       out_ready;

    data_beat_t exp_q [$];
    int         gen_len_q [$];
    data_beat_t mon_exp;
    int         gen_count = 0;
    int         gen_expect;
    int         err_count = 0;
    int         check_count = 0;
    int         errs_before;
    integer     seed = 32'h91b0ee79;

    tb_clock u_clock (
        .clk   (clk),
        .reset (reset)
    );

    nd_frame_reader #(
        .cmd_regs   (cmd_regs),
        .len_offset (len_offset)
    ) dut (
        .clk       (clk),
        .reset     (reset),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .cmd_ready (cmd_ready),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .out       (out),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    // ------------------------------------------------------------
    // compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input string name, input data_t exp, input data_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flags(input string name, input dim_flags_t exp, input dim_flags_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_user(input string name, input user_t exp, input user_t act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        check_count++;
        if (act !== exp) begin
            err_count++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic note_timeout(input string what);
        err_count++;
        $display("timeout at %0t: %s", $time, what);
    endtask

    // ------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------
    // RAM fill pattern
    function automatic data_t word_value(input addr_t a);
        return data_t'(a) ^ 16'ha5c3;
    endfunction

    function automatic nd_cmd_t make_cmd(input addr_t base, input step_t s0, input step_t s1,
                                         input step_t s2, input len_t l0, input len_t l1,
                                         input len_t l2, input user_t user);
        nd_cmd_t c;
        c.base    = base;
        c.step[0] = s0;
        c.step[1] = s1;
        c.step[2] = s2;
        c.len[0]  = l0;
        c.len[1]  = l1;
        c.len[2]  = l2;
        c.user    = user;
        return c;
    endfunction

    // every beat of a command in index order, i0 fastest
    function automatic void expand_cmd(input nd_cmd_t c);
        int         n [dims];
        int         idx [dims];
        int         sum;
        bit         all_first;
        bit         all_last;
        data_beat_t b;
        for (int k = 0; k < dims; k++) begin
            n[k] = int'(c.len[k]) + len_offset;
        end
        for (int i2 = 0; i2 < n[2]; i2++) begin
            for (int i1 = 0; i1 < n[1]; i1++) begin
                for (int i0 = 0; i0 < n[0]; i0++) begin
                    idx[0] = i0;
                    idx[1] = i1;
                    idx[2] = i2;
                    sum = int'(c.base);
                    all_first = 1'b1;
                    all_last  = 1'b1;
                    for (int k = 0; k < dims; k++) begin
                        sum = sum + idx[k] * int'($signed(c.step[k]));
                        all_first  = all_first && (idx[k] == 0);
                        all_last   = all_last && (idx[k] == n[k] - 1);
                        b.first[k] = all_first;
                        b.last[k]  = all_last;
                    end
                    // wraps modulo the RAM size
                    b.data = word_value(addr_t'(sum));
                    b.user = c.user;
                    exp_q.push_back(b);
                end
            end
        end
        gen_len_q.push_back(n[0] * n[1] * n[2]);
    endfunction

    // ------------------------------------------------------------
    // monitors
    // ------------------------------------------------------------
    always @(posedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                err_count++;
                $display("output beat %h arrived at %0t with none expected", out.data, $time);
            end else begin
                mon_exp = exp_q.pop_front();
                check_data("out.data", mon_exp.data, out.data);
                check_flags("out.first", mon_exp.first, out.first);
                check_flags("out.last", mon_exp.last, out.last);
                check_user("out.user", mon_exp.user, out.user);
            end
        end
    end

    // generator may only release a command with its final beat
    always @(posedge clk) begin
        if (!reset && dut.beat_valid && dut.beat_ready) begin
            gen_count++;
        end
        if (!reset && dut.gen_cmd_ready) begin
            if (gen_len_q.size() == 0) begin
                err_count++;
                $display("generator released a command that was never sent");
            end else begin
                gen_expect = gen_len_q.pop_front();
                if (gen_count != gen_expect) begin
                    err_count++;
                    $display("generator released a command after %0d beats instead of %0d",
                             gen_count, gen_expect);
                end
            end
            gen_count = 0;
        end
    end

    // ------------------------------------------------------------
    // drivers
    // ------------------------------------------------------------
    task automatic preload_ram();
        for (int a = 0; a < 2**addr_w; a++) begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = addr_t'(a);
            wr_data = word_value(addr_t'(a));
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    // cmd_valid stays high after the transfer until the next drive
    task automatic send_cmd(input nd_cmd_t c);
        int n;
        bit done;
        expand_cmd(c);
        @(negedge clk);
        cmd       = c;
        cmd_valid = 1'b1;
        n    = 0;
        done = 1'b0;
        while (!done && n < accept_limit) begin
            @(posedge clk);
            done = cmd_ready;
            n++;
        end
        if (!done) begin
            note_timeout("command was never accepted");
        end
    endtask

    task automatic wait_drain(input bit rand_ready);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < drain_limit) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            out_ready = rand_ready ? (($random(seed) & 1) != 0) : 1'b1;
            n++;
        end
        if (exp_q.size() != 0) begin
            note_timeout($sformatf("%0d output beats never arrived", exp_q.size()));
            exp_q.delete();
        end
        // quiet period catches repeated beats
        repeat (6) begin
            @(negedge clk);
            cmd_valid = 1'b0;
            out_ready = 1'b1;
        end
        if (gen_len_q.size() != 0) begin
            err_count++;
            $display("%0d commands were never released by the generator", gen_len_q.size());
            gen_len_q.delete();
        end
    endtask

    task automatic report_test(input int num, input string name);
        $display("test %0d %s done, %0d errors", num, name, err_count - errs_before);
        errs_before = err_count;
    endtask

    // ------------------------------------------------------------
    // tests
    // ------------------------------------------------------------
    task automatic test_idle();
        repeat (20) begin
            @(posedge clk);
            check_bit("out_valid", 1'b0, out_valid);
            check_bit("cmd_ready", 1'b0, cmd_ready);
        end
        report_test(1, "idle after reset");
    endtask

    task automatic test_single();
        send_cmd(make_cmd(10'h2a7, 10'sd3, 10'sd17, 10'sd100, 8'd0, 8'd0, 8'd0, 4'h3));
        wait_drain(1'b0);
        report_test(2, "single beat");
    endtask

    task automatic test_scan();
        send_cmd(make_cmd(10'h040, 10'sd1, 10'sd8, 10'sd64, 8'd3, 8'd2, 8'd1, 4'h5));
        wait_drain(1'b0);
        report_test(3, "4x3x2 scan");
    endtask

    task automatic test_backpressure();
        send_cmd(make_cmd(10'h002, -10'sd1, 10'sd8, 10'sd64, 8'd3, 8'd2, 8'd1, 4'h9));
        wait_drain(1'b1);
        report_test(4, "scan under back-pressure");
    endtask

    task automatic test_back_to_back();
        send_cmd(make_cmd(10'h300, 10'sd2, 10'sd32, 10'sd0, 8'd1, 8'd1, 8'd0, 4'h1));
        send_cmd(make_cmd(10'h3f0, 10'sd3, 10'sd0, 10'sd100, 8'd2, 8'd0, 8'd1, 4'h2));
        send_cmd(make_cmd(10'h010, 10'sd5, -10'sd16, 10'sd7, 8'd0, 8'd3, 8'd0, 4'h7));
        wait_drain(1'b0);
        report_test(5, "back-to-back commands");
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int n;
        int assert_fails;
        cmd       = '0;
        cmd_valid = 1'b0;
        wr_en     = 1'b0;
        wr_addr   = '0;
        wr_data   = '0;
        out_ready = 1'b1;
        errs_before = 0;

        n = 0;
        while (reset !== 1'b0 && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (reset !== 1'b0) begin
            note_timeout("reset was never released");
        end

        test_idle();
        preload_ram();
        test_single();
        test_scan();
        test_backpressure();
        test_back_to_back();

        assert_fails = dut.u_read_pipe.u_props.fail_count;
        $display("tests 5, checks %0d, errors %0d, assertion failures %0d",
                 check_count, err_count, assert_fails);
        if (err_count == 0 && assert_fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // whole-run limit
    initial begin
        #100us;
        $display("simulation ran past its time limit");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* sim/nd_frame_reader_props.sv */
/*
 * handshake assertions for the read stage
 * beat and out hold while stalled, out idle after reset
 */

module nd_frame_reader_props import nd_stream_pkg::*; (
    input logic       clk,
    input logic       reset,
    input addr_beat_t beat,
    input logic       beat_valid,
    input logic       beat_ready,
    input data_beat_t out,
    input logic       out_valid,
    input logic       out_ready
);

    timeunit 1ns;
    timeprecision 1ps;

    // failed assertions, read by the testbench at the end
    int fail_count = 0;

    // ------------------------------------------------------------
    // input side
    // ------------------------------------------------------------
    beat_hold: assert property (@(posedge clk) disable iff (reset)
        beat_valid && !beat_ready |=> beat_valid && $stable(beat))
    else begin
        fail_count++;
        $error("address beat changed or dropped while stalled");
    end

    // ------------------------------------------------------------
    // output side
    // ------------------------------------------------------------
    out_hold: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable(out))
    else begin
        fail_count++;
        $error("output beat changed or dropped while stalled");
    end

    out_idle: assert property (@(posedge clk) reset |=> !out_valid)
    else begin
        fail_count++;
        $error("out_valid high right after reset");
    end

endmodule

bind read_pipe nd_frame_reader_props u_props (
    .clk        (clk),
    .reset      (reset),
    .beat       (beat),
    .beat_valid (beat_valid),
    .beat_ready (beat_ready),
    .out        (out),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
);

/* sim/tb_clock.sv */
/*
 * clock and reset for the testbench
 * 4 ns period, reset held for 8 cycles
 */

module tb_clock #(
    parameter realtime period = 4.0ns,
    parameter int reset_cycles = 8
) (
    output logic clk,
    output logic reset
);

    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

/* src/nd_frame_reader.sv */
/*
 * strided frame reader top level
 * command slice, address generator, read stage and frame RAM
 */

module nd_frame_reader import nd_types_pkg::*; import nd_stream_pkg::*; #(
    parameter bit cmd_regs   = 1'b1,
    parameter int len_offset = 1
) (
    input  logic       clk,
    input  logic       reset,
    input  nd_cmd_t    cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    input  logic       wr_en,
    input  addr_t      wr_addr,
    input  data_t      wr_data,
    output data_beat_t out,
    output logic       out_valid,
    input  logic       out_ready
);

    // slice to generator
    nd_cmd_t    gen_cmd;
    logic       gen_cmd_valid;
    logic       gen_cmd_ready;

    // generator to read stage
    addr_beat_t beat;
    logic       beat_valid;
    logic       beat_ready;

    // read stage to RAM
    logic       rd_en;
    addr_t      rd_addr;
    data_t      rd_data;

    cmd_slice #(
        .cmd_regs (cmd_regs)
    ) u_cmd_slice (
        .clk     (clk),
        .reset   (reset),
        .s_cmd   (cmd),
        .s_valid (cmd_valid),
        .s_ready (cmd_ready),
        .m_cmd   (gen_cmd),
        .m_valid (gen_cmd_valid),
        .m_ready (gen_cmd_ready)
    );

    nd_addr_gen #(
        .len_offset (len_offset)
    ) u_addr_gen (
        .clk        (clk),
        .reset      (reset),
        .cmd        (gen_cmd),
        .cmd_valid  (gen_cmd_valid),
        .cmd_ready  (gen_cmd_ready),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready)
    );

    read_pipe u_read_pipe (
        .clk        (clk),
        .reset      (reset),
        .beat       (beat),
        .beat_valid (beat_valid),
        .beat_ready (beat_ready),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .rd_data    (rd_data),
        .out        (out),
        .out_valid  (out_valid),
        .out_ready  (out_ready)
    );

    frame_ram u_frame_ram (
        .clk     (clk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

/* src/read_pipe.sv */
/*
 * read stage between address beats and the output stream
 * one RAM read per beat, flags and tag delayed to meet the data
 * two-entry output buffer absorbs back-pressure
 */

module read_pipe import nd_types_pkg::*; import nd_stream_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  addr_beat_t beat,
    input  logic       beat_valid,
    output logic       beat_ready,
    output logic       rd_en,
    output addr_t      rd_addr,
    input  data_t      rd_data,
    output data_beat_t out,
    output logic       out_valid,
    input  logic       out_ready
);

    // read in flight, its side fields wait for the RAM data
    logic       pend_valid;
    dim_flags_t pend_first;
    dim_flags_t pend_last;
    user_t      pend_user;

    // output buffer
    data_beat_t fifo_mem [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;

    logic [1:0] held;
    logic       take;
    logic       pop;

    // ------------------------------------------------------------
    // accept and issue
    // ------------------------------------------------------------
    assign pop  = out_valid && out_ready;
    // stored entries plus the read still on its way
    assign held = count + {1'b0, pend_valid};

    // one entry must stay free for the read issued now
    assign beat_ready = (held - {1'b0, pop}) <= 2'd1;
    assign take       = beat_valid && beat_ready;

    assign rd_en   = take;
    assign rd_addr = beat.addr;

    // ------------------------------------------------------------
    // control
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            pend_valid <= 1'b0;
            wr_ptr     <= 1'b0;
            rd_ptr     <= 1'b0;
            count      <= 2'd0;
        end else begin
            pend_valid <= take;
            if (pend_valid) begin
                wr_ptr <= !wr_ptr;
            end
            if (pop) begin
                rd_ptr <= !rd_ptr;
            end
            count <= count + {1'b0, pend_valid} - {1'b0, pop};
        end
    end

    // ------------------------------------------------------------
    // payload
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (take) begin
            pend_first <= beat.first;
            pend_last  <= beat.last;
            pend_user  <= beat.user;
        end
        if (pend_valid) begin
            fifo_mem[wr_ptr] <= '{
                data:  rd_data,
                first: pend_first,
                last:  pend_last,
                user:  pend_user
            };
        end
    end

    assign out       = fifo_mem[rd_ptr];
    assign out_valid = count != 2'd0;

endmodule

/* src/frame_ram.sv */
/*
 * frame memory, 1024 words
 * one write port, one registered read port
 */

module frame_ram import nd_types_pkg::*; (
    input  logic  clk,
    input  logic  wr_en,
    input  addr_t wr_addr,
    input  data_t wr_data,
    input  logic  rd_en,
    input  addr_t rd_addr,
    output data_t rd_data
);

    data_t mem [2**addr_w];

    // write lands at the edge
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read data valid one cycle after rd_en
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

/* addr_gen/nd_addr_gen.sv */
/*
 * multi-dimensional address walker, dimension 0 innermost
 * running address and remaining count per dimension
 * first/last flags per dimension, command held until the final beat
 */

module nd_addr_gen import nd_types_pkg::*; import nd_stream_pkg::*; #(
    parameter int len_offset = 1
) (
    input  logic       clk,
    input  logic       reset,
    input  nd_cmd_t    cmd,
    input  logic       cmd_valid,
    output logic       cmd_ready,
    output addr_beat_t beat,
    output logic       beat_valid,
    input  logic       beat_ready
);

    // current beat
    addr_t      run_addr [dims];
    len_t       run_len  [dims];
    dim_flags_t run_first;
    dim_flags_t run_last;
    user_t      run_user;
    logic       run_valid;

    // state after this edge
    addr_t      next_addr [dims];
    len_t       next_len  [dims];
    dim_flags_t next_first;
    dim_flags_t next_last;
    user_t      next_user;
    logic       next_valid;

    logic       step_en;
    logic       carry;
    logic       all_zero;

    // remaining count after the first beat of a dimension
    function automatic len_t start_len(input len_t len);
        return len - len_t'(1 - len_offset);
    endfunction

    assign step_en   = run_valid && beat_ready;
    // command is released together with the final beat
    assign cmd_ready = step_en && run_last[dims-1];

    // ------------------------------------------------------------
    // next state
    // ------------------------------------------------------------
    always_comb begin
        next_addr  = run_addr;
        next_len   = run_len;
        next_first = run_first;
        next_user  = run_user;
        next_valid = run_valid;
        carry      = 1'b1;

        if (!run_valid && cmd_valid) begin
            // start of a command, every dimension at index 0
            for (int i = 0; i < dims; i++) begin
                next_addr[i] = cmd.base;
                next_len[i]  = start_len(cmd.len[i]);
            end
            next_first = '1;
            next_user  = cmd.user;
            next_valid = 1'b1;
        end else if (step_en) begin
            if (run_last[dims-1]) begin
                next_valid = 1'b0;
            end else begin
                // wrapped inner dimensions restart at index 0
                next_first = run_last;

                // carry from inner to outer, stop at the first non-wrapping dim
                for (int i = 0; i < dims; i++) begin
                    if (carry) begin
                        if (run_last[i]) begin
                            next_len[i] = start_len(cmd.len[i]);
                        end else begin
                            next_len[i]  = run_len[i] - len_t'(1);
                            next_addr[i] = run_addr[i] + addr_t'(cmd.step[i]);
                            carry        = 1'b0;
                        end
                    end
                end

                // reload wrapped addresses from the outer running address
                for (int i = dims - 2; i >= 0; i--) begin
                    if (run_last[i]) begin
                        next_addr[i] = next_addr[i+1];
                    end
                end
            end
        end

        // last[k] needs every dimension up to k at its end
        all_zero = 1'b1;
        for (int i = 0; i < dims; i++) begin
            all_zero     = all_zero && (next_len[i] == '0);
            next_last[i] = all_zero;
        end
    end

    // ------------------------------------------------------------
    // registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            run_valid <= 1'b0;
        end else begin
            run_valid <= next_valid;
        end
    end

    always_ff @(posedge clk) begin
        run_addr  <= next_addr;
        run_len   <= next_len;
        run_first <= next_first;
        run_last  <= next_last;
        run_user  <= next_user;
    end

    assign beat = '{
        addr:  run_addr[0],
        first: run_first,
        last:  run_last,
        user:  run_user
    };
    assign beat_valid = run_valid;

endmodule

/* src/cmd_slice.sv */
/*
 * command register slice with skid register
 * full rate when registered, plain wires when cmd_regs is 0
 */

module cmd_slice import nd_stream_pkg::*; #(
    parameter bit cmd_regs = 1'b1
) (
    input  logic    clk,
    input  logic    reset,
    input  nd_cmd_t s_cmd,
    input  logic    s_valid,
    output logic    s_ready,
    output nd_cmd_t m_cmd,
    output logic    m_valid,
    input  logic    m_ready
);

    generate
        if (cmd_regs) begin : g_regs
            nd_cmd_t main_cmd;
            nd_cmd_t skid_cmd;
            logic    main_valid;
            logic    skid_valid;
            logic    load_main;

            // main register free or being drained this cycle
            assign load_main = !main_valid || m_ready;

            // ready only offered against a pending command, never while skid is full
            assign s_ready = s_valid && !skid_valid;

            always_ff @(posedge clk) begin
                if (reset) begin
                    main_valid <= 1'b0;
                    skid_valid <= 1'b0;
                end else if (load_main) begin
                    main_valid <= skid_valid || s_valid;
                    skid_valid <= 1'b0;
                end else if (s_ready) begin
                    skid_valid <= 1'b1;
                end
            end

            always_ff @(posedge clk) begin
                if (load_main) begin
                    main_cmd <= skid_valid ? skid_cmd : s_cmd;
                end
                // park the incoming command while the output is stalled
                if (s_ready && !load_main) begin
                    skid_cmd <= s_cmd;
                end
            end

            assign m_cmd   = main_cmd;
            assign m_valid = main_valid;
        end else begin : g_wires
            assign m_cmd   = s_cmd;
            assign m_valid = s_valid;
            assign s_ready = m_ready;
        end
    endgenerate

endmodule

/* common/nd_stream_pkg.sv */
/*
 * packed structs carried on the handshake paths
 * command, address beat and output data beat
 */

package nd_stream_pkg;

    import nd_types_pkg::*;

    // ------------------------------------------------------------
    // command into the generator
    // ------------------------------------------------------------
    // 68 bits, step[0] and len[0] describe the innermost dimension
    typedef struct packed {
        addr_t                 base;
        step_t [dims-1:0]      step;
        len_t  [dims-1:0]      len;
        user_t                 user;
    } nd_cmd_t;

    // ------------------------------------------------------------
    // generator to read stage
    // ------------------------------------------------------------
    typedef struct packed {
        addr_t      addr;
        dim_flags_t first;
        dim_flags_t last;
        user_t      user;
    } addr_beat_t;

    // ------------------------------------------------------------
    // read stage to output stream
    // ------------------------------------------------------------
    // same flags and tag as the beat that produced the read
    typedef struct packed {
        data_t      data;
        dim_flags_t first;
        dim_flags_t last;
        user_t      user;
    } data_beat_t;

endpackage

/* common/nd_types_pkg.sv */
/*
 * width constants for the strided frame reader
 * vector typedefs for addresses, steps, lengths, data and tags
 */

package nd_types_pkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------
    localparam int dims   = 3;
    localparam int addr_w = 10;
    localparam int step_w = 10;
    localparam int len_w  = 8;
    localparam int data_w = 16;
    localparam int user_w = 4;

    // ------------------------------------------------------------
    // vectors
    // ------------------------------------------------------------
    // frame RAM word address
    typedef logic [addr_w-1:0] addr_t;
    // per-dimension increment, may be negative
    typedef logic signed [step_w-1:0] step_t;
    // length code, meaning depends on len_offset
    typedef logic [len_w-1:0] len_t;
    typedef logic [data_w-1:0] data_t;
    typedef logic [user_w-1:0] user_t;
    // one bit per dimension, bit 0 innermost
    typedef logic [dims-1:0] dim_flags_t;

endpackage
